// File: test/pcoeffCases.mem
// columns: startNewTop, bot (128 bits), expected summedData, expected pcoeffCount
// flag 1 loads bot as the new top, its expected columns are unused
0 0 0 0
1 ffffffffffffffffffffffffffffffff 0 0
0 ffffffffffffffffffffffffffffffff 1 1
0 0 3 2
0 1 5 3
0 fffffffffffffffffffffffffffffff6 9 4
0 fffffffffffffffffffffffffffffffc b 5
0 7fffffffffffffffffffffffffffffff d 6
1 ff 0 0
0 0f 2 1
0 100 2 1
0 66 6 2
0 96 16 3
0 ff 17 4
0 1ff 17 4
1 1969669699669969669 0 0
0 0 2000000000 1
0 0 0 2
0 1 1000000000 3
1 1 0 0
0 1 1 1
0 0 3 2
0 1 4 3
0 0 6 4
0 1 7 5
0 0 9 6
0 1 a 7
0 0 c 0
0 1 d 1
0 2 d 1

// File: src.f
verilog/pcoeffPkg.sv
verilog/topBotStage.sv
verilog/skidBuffer.sv
verilog/componentCounter.sv
verilog/pcoeffAccumulator.sv
verilog/pcoeffPipeline.sv
test/pcoeffPipelineTb.sv

// File: Makefile
SIM       = verilator
TOP       = pcoeffPipelineTb
RTL_TOP   = pcoeffPipeline
FILELIST  = src.f
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
BUILD     = obj_dir
LOG       = sim.log
SRCS      = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/pcoeffPipelineTb.sv
`timescale 1ns/100ps
`default_nettype none

module pcoeffPipelineTb import pcoeffPkg::*; ();

    localparam int maxCases = 64;
    localparam int stallLimit = 200;   // cycles one word may wait for inReady
    localparam int resultLimit = 400;  // cycles between two results
    localparam int drainCycles = 30;

    logic                  clk;
    logic                  rst;
    logic                  inValid;
    logic                  inReady;
    logic                  startNewTop;
    boolFunc_t             bot;
    logic                  outValid;
    logic                  outReady;
    logic [sumWidth-1:0]   summedData;
    logic [countWidth-1:0] pcoeffCount;

    // four entries per case: flag, bot, sum, count
    boolFunc_t             caseMem [0:4*maxCases-1];
    int                    numCases;
    int                    numBots;
    logic [sumWidth-1:0]   expSum [$];
    logic [countWidth-1:0] expCount [$];
    int                    mismatches;
    int                    otherErrors;
    int unsigned           lcgState;

    pcoeffPipeline dut (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .startNewTop(startNewTop), .bot(bot),
        .outValid(outValid), .outReady(outReady),
        .summedData(summedData), .pcoeffCount(pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 1664525 + 1013904223;
        return lcgState;
    endfunction

    // true in roughly the given percentage of calls
    function automatic logic chance(int unsigned percent);
        return ((nextRand() >> 16) % 100) < percent;
    endfunction

    task automatic loadCases();
        // flag column of an unread line can never be 0 or 1
        for (int i = 0; i < 4*maxCases; i++) begin
            caseMem[i] = ~funcWidth'(i);
        end
        $readmemh("test/pcoeffCases.mem", caseMem);
        numCases = 0;
        numBots = 0;
        while (numCases < maxCases && caseMem[4*numCases] <= funcWidth'(1)) begin
            if (caseMem[4*numCases] == funcWidth'(0)) begin
                expSum.push_back(caseMem[4*numCases+2][sumWidth-1:0]);
                expCount.push_back(caseMem[4*numCases+3][countWidth-1:0]);
                numBots++;
            end
            numCases++;
        end
    endtask

    task automatic checkResult();
        logic [sumWidth-1:0]   wantSum;
        logic [countWidth-1:0] wantCount;
        assert (expSum.size() > 0) else begin
            $display("result %h/%h came out with no bot left to match it",
                     summedData, pcoeffCount);
            otherErrors++;
        end
        if (expSum.size() > 0) begin
            wantSum = expSum.pop_front();
            wantCount = expCount.pop_front();
            assert (summedData == wantSum) else begin
                $display("Mismatch summedData: got %h, expected %h", summedData, wantSum);
                mismatches++;
            end
            assert (pcoeffCount == wantCount) else begin
                $display("Mismatch pcoeffCount: got %h, expected %h", pcoeffCount, wantCount);
                mismatches++;
            end
        end
    endtask

    initial begin : stimulus
        int   sent;
        int   received;
        int   waitCycles;
        int   idleCycles;
        logic holding;
        lcgState = 60771;
        mismatches = 0;
        otherErrors = 0;
        rst = 1'b0;
        inValid = 1'b0;
        startNewTop = 1'b0;
        bot = '0;
        outReady = 1'b0;
        loadCases();
        assert (numBots > 0) else begin
            $display("no bot cases read from test/pcoeffCases.mem");
            otherErrors++;
        end

        repeat (8) @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);
        assert (!outValid) else begin
            $display("outValid is high right after reset");
            otherErrors++;
        end
        assert (inReady) else begin
            $display("inReady is low right after reset");
            otherErrors++;
        end

        sent = 0;
        received = 0;
        waitCycles = 0;
        idleCycles = 0;
        holding = 1'b0;
        while (received < numBots || sent < numCases) begin
            @(posedge clk);
            #1;
            // a word once shown stays until it is taken
            if (!holding && sent < numCases && chance(75)) begin
                startNewTop = caseMem[4*sent][0];
                bot = caseMem[4*sent+1];
                holding = 1'b1;
            end
            inValid = holding;
            outReady = chance(70);

            @(negedge clk);
            if (inValid && inReady) begin
                sent++;
                holding = 1'b0;
                waitCycles = 0;
            end else if (inValid) begin
                waitCycles++;
            end
            if (outValid && outReady) begin
                checkResult();
                received++;
                idleCycles = 0;
            end else begin
                idleCycles++;
            end

            if (waitCycles > stallLimit) begin
                $display("timeout: input line %0d was never accepted", sent);
                otherErrors++;
                break;
            end
            if (idleCycles > resultLimit) begin
                $display("timeout: only %0d of %0d results arrived", received, numBots);
                otherErrors++;
                break;
            end
        end

        // nothing more may come out
        @(posedge clk);
        #1;
        inValid = 1'b0;
        outReady = 1'b1;
        repeat (drainCycles) begin
            @(negedge clk);
            assert (!outValid) else begin
                $display("extra result %h/%h after the last bot", summedData, pcoeffCount);
                otherErrors++;
            end
        end
        assert (received == numBots) else begin
            $display("got %0d results for %0d bots", received, numBots);
            otherErrors++;
        end

        $display("result check: %0d mismatches, %0d other errors", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/pcoeffPipeline.sv
`timescale 1ns/100ps
`default_nettype none

module pcoeffPipeline import pcoeffPkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  inValid,
    output logic                  inReady,
    input  logic                  startNewTop,
    input  boolFunc_t             bot,

    output logic                  outValid,
    input  logic                  outReady,
    output logic [sumWidth-1:0]   summedData,
    output logic [countWidth-1:0] pcoeffCount
);

    // top/bot stage to graph buffer
    logic       stageValid;
    logic       stageReady;
    graphItem_t stageItem;

    // graph buffer to counter
    logic       graphValid;
    logic       graphReady;
    graphItem_t graphItem;

    // counter to accumulator
    logic                 countValid;
    logic                 countReady;
    logic [compWidth-1:0] components;
    logic                 isSubset;
    logic                 newTop;

    // accumulator to result buffer
    logic        accValid;
    logic        accReady;
    resultItem_t accItem;
    resultItem_t resultItem;

    topBotStage topBot (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .startNewTop(startNewTop), .bot(bot),
        .outValid(stageValid), .outReady(stageReady), .outItem(stageItem)
    );

    skidBuffer #(.payload_t(graphItem_t)) graphBuf (
        .clk(clk), .rst(rst),
        .inValid(stageValid), .inReady(stageReady), .inData(stageItem),
        .outValid(graphValid), .outReady(graphReady), .outData(graphItem)
    );

    componentCounter counter (
        .clk(clk), .rst(rst),
        .inValid(graphValid), .inReady(graphReady), .inItem(graphItem),
        .outValid(countValid), .outReady(countReady),
        .components(components), .isSubset(isSubset), .newTop(newTop)
    );

    pcoeffAccumulator accumulator (
        .clk(clk), .rst(rst),
        .inValid(countValid), .inReady(countReady),
        .components(components), .isSubset(isSubset), .newTop(newTop),
        .outValid(accValid), .outReady(accReady), .outItem(accItem)
    );

    skidBuffer #(.payload_t(resultItem_t)) resultBuf (
        .clk(clk), .rst(rst),
        .inValid(accValid), .inReady(accReady), .inData(accItem),
        .outValid(outValid), .outReady(outReady), .outData(resultItem)
    );

    assign summedData = resultItem.summedData;
    assign pcoeffCount = resultItem.pcoeffCount;

endmodule

`default_nettype wire

// File: verilog/pcoeffAccumulator.sv
`timescale 1ns/100ps
`default_nettype none

module pcoeffAccumulator import pcoeffPkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // component counts in
    input  logic                 inValid,
    output logic                 inReady,
    input  logic [compWidth-1:0] components,
    input  logic                 isSubset,
    input  logic                 newTop,

    // running results out
    output logic                 outValid,
    input  logic                 outReady,
    output resultItem_t          outItem
);

    logic [sumWidth-1:0]   sumReg;
    logic [countWidth-1:0] countReg;
    logic [sumWidth-1:0]   pcoeff;
    logic [sumWidth-1:0]   baseSum;
    logic [countWidth-1:0] baseCount;
    logic                  accept;

    assign inReady = !outValid || outReady;
    assign accept = inValid && inReady;

    // 2^components, falls off the top for counts of 38 and up
    assign pcoeff = isSubset ? (sumWidth'(1) << components) : '0;

    // new top restarts from this item
    assign baseSum = newTop ? '0 : sumReg;
    assign baseCount = newTop ? '0 : countReg;

    // registers hold until the next accept, so they are the output slot
    assign outItem.summedData = sumReg;
    assign outItem.pcoeffCount = countReg;

    always_ff @(posedge clk) begin
        if (!rst) begin
            outValid <= 1'b0;
            sumReg <= '0;
            countReg <= '0;
        end else begin
            if (outValid && outReady) begin
                outValid <= 1'b0;
            end
            if (accept) begin
                outValid <= 1'b1;
                sumReg <= baseSum + pcoeff; // wraps at 2^38
                countReg <= baseCount + countWidth'(isSubset); // nonzero pcoeff only
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/componentCounter.sv
`timescale 1ns/100ps
`default_nettype none

module componentCounter import pcoeffPkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // graph items in
    input  logic                 inValid,
    output logic                 inReady,
    input  graphItem_t           inItem,

    // component count out, with flags passed along
    output logic                 outValid,
    input  logic                 outReady,
    output logic [compWidth-1:0] components,
    output logic                 isSubset,
    output logic                 newTop
);

    typedef enum logic [1:0] {
        stIdle,
        stExpand,
        stDone
    } state_t;

    state_t    state;
    boolFunc_t remaining; // points not yet assigned to a component
    boolFunc_t frontier;  // current component being flooded
    boolFunc_t grown;
    boolFunc_t cleared;
    logic      frontierDone;
    logic      lastComponent;

    // isolate the lowest set point
    function automatic boolFunc_t lowestPoint(boolFunc_t f);
        return f & (~f + 1'b1);
    endfunction

    // frontier plus all neighbours one variable flip away
    function automatic boolFunc_t growFrontier(boolFunc_t f);
        boolFunc_t g;
        g = f;
        for (int p = 0; p < funcWidth; p++) begin
            for (int v = 0; v < numVars; v++) begin
                g[p] = g[p] | f[p ^ (1 << v)];
            end
        end
        return g;
    endfunction

    assign grown = growFrontier(frontier) & remaining;
    assign cleared = remaining & ~frontier;
    assign frontierDone = (grown == frontier); // component fully flooded
    assign lastComponent = (cleared == '0);

    assign inReady = (state == stIdle);
    assign outValid = (state == stDone);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (inValid) begin
                        // empty graph skips straight to the result
                        state <= (inItem.graph == '0) ? stDone : stExpand;
                    end
                end
                stExpand: begin
                    if (frontierDone && lastComponent) begin
                        state <= stDone;
                    end
                end
                stDone: begin
                    if (outReady) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // flood fill datapath
    always_ff @(posedge clk) begin
        case (state)
            stIdle: begin
                if (inValid) begin
                    remaining <= inItem.graph;
                    frontier <= lowestPoint(inItem.graph); // seed
                    components <= '0;
                    isSubset <= inItem.isSubset;
                    newTop <= inItem.newTop;
                end
            end
            stExpand: begin
                if (frontierDone) begin
                    // retire this component, seed the next one
                    remaining <= cleared;
                    frontier <= lowestPoint(cleared);
                    components <= components + compWidth'(1);
                end else begin
                    frontier <= grown;
                end
            end
            default: begin
                // result held until the transfer
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/skidBuffer.sv
`timescale 1ns/100ps
`default_nettype none

// one-entry registered stage between two handshakes
module skidBuffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    // upstream side
    input  logic     inValid,
    output logic     inReady,
    input  payload_t inData,

    // downstream side
    output logic     outValid,
    input  logic     outReady,
    output payload_t outData
);

    logic full;
    logic load;

    assign outValid = full;

    // empty, or full and draining this cycle
    assign inReady = !full || outReady;
    assign load = inValid && inReady;

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (outReady) begin
            full <= 1'b0; // drained with nothing behind it
        end
    end

    // payload held while waiting for outReady
    always_ff @(posedge clk) begin
        if (load) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: verilog/topBotStage.sv
`timescale 1ns/100ps
`default_nettype none

module topBotStage import pcoeffPkg::*; (
    input  logic       clk,
    input  logic       rst,

    // word stream from outside
    input  logic       inValid,
    output logic       inReady,
    input  logic       startNewTop,
    input  boolFunc_t  bot,

    // graph items toward the counter
    output logic       outValid,
    input  logic       outReady,
    output graphItem_t outItem
);

    boolFunc_t top;
    logic      topValid;      // no top stored yet after reset
    logic      pendingNewTop; // marks the next bot as first of a top
    logic      accept;
    logic      botFits;

    // the output slot frees up when empty or being drained
    assign inReady = !outValid || outReady;
    assign accept = inValid && inReady;

    // empty top fails every subset test
    assign botFits = topValid && ((bot & ~top) == '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            outValid <= 1'b0;
            top <= '0;
            topValid <= 1'b0;
            pendingNewTop <= 1'b0;
        end else begin
            if (outValid && outReady) begin
                outValid <= 1'b0;
            end
            if (accept) begin
                if (startNewTop) begin
                    top <= bot;
                    topValid <= 1'b1;
                    pendingNewTop <= 1'b1; // top load gives no output
                end else begin
                    outValid <= 1'b1;
                    pendingNewTop <= 1'b0;
                end
            end
        end
    end

    // graph item toward the counter
    always_ff @(posedge clk) begin
        if (accept && !startNewTop) begin
            outItem.graph <= top & ~bot;
            outItem.isSubset <= botFits;
            outItem.newTop <= pendingNewTop;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pcoeffPkg.sv
`default_nettype none

package pcoeffPkg;

    // function geometry
    localparam int funcWidth = 128;    // points of a 7-variable function
    localparam int numVars = 7;        // hypercube dimension

    // output widths
    localparam int sumWidth = 38;
    localparam int countWidth = 3;

    // up to 64 components in the 7-cube
    localparam int compWidth = 7;

    // one bit per point, indexed by point number
    typedef logic [funcWidth-1:0] boolFunc_t;

    // handed from the top/bot stage to the component counter
    typedef struct packed {
        boolFunc_t graph;    // points in top but not in bot
        logic      isSubset; // bot fits inside top
        logic      newTop;   // first bot after a top load
    } graphItem_t;

    // final result toward the output port
    typedef struct packed {
        logic [sumWidth-1:0]   summedData;
        logic [countWidth-1:0] pcoeffCount;
    } resultItem_t;

endpackage

`default_nettype wire
